/* mem_cfg_pkg.sv */
// ########################################
// default memory sizes of the block mover.
// the top level passes these down as module
// parameters, they are referenced by scope.
// ########################################

package mem_cfg_pkg;

	// address width in bits, giving 2^ADDR_BITS_DEF words.
	localparam int ADDR_BITS_DEF = 8;

	// word width in bits.
	// sums over a region wrap modulo 2^WORD_BITS_DEF.
	localparam int WORD_BITS_DEF = 8;

endpackage

/* mem_cmd_pkg.sv */
// ########################################
// opcode and FSM state encodings of the
// block-transfer engine.
// ########################################

package mem_cmd_pkg;

	// operations a command can run over a region of words.
	typedef enum logic [1:0] {
		OP_FILL = 2'd0,
		OP_COPY = 2'd1,
		OP_SUM  = 2'd2
	} mem_op_t;

	// states of the transfer FSM.
	// ST_DRAIN lets the last word leave the write stage.
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_RUN   = 2'd1,
		ST_DRAIN = 2'd2,
		ST_DONE  = 2'd3
	} xfer_state_t;

endpackage

/* ram_2port.sv */
// ########################################
// two-port synchronous RAM.
// port 1 reads and writes, port 2 reads only.
// both read ports have a registered output
// that holds while the read enable is low.
// ########################################

`timescale 1ns/1ns

module ram_2port #(
	parameter int ADDR_BITS = 8,
	parameter int WORD_BITS = 8
) (
	input  logic                 clk,

	// port 1, reading and writing.
	input  logic                 read_ena_1,
	input  logic                 write_ena_1,
	input  logic [ADDR_BITS-1:0] addr_1,
	input  logic [WORD_BITS-1:0] wdata_1,
	output logic [WORD_BITS-1:0] rdata_1,

	// port 2, reading only.
	input  logic                 read_ena_2,
	input  logic [ADDR_BITS-1:0] addr_2,
	output logic [WORD_BITS-1:0] rdata_2
);

	localparam int NUM_WORDS = 1 << ADDR_BITS;

	logic [WORD_BITS-1:0] mem [0:NUM_WORDS-1];

	// port 1 writes at the edge.
	// a read on the same edge would see the old word.
	always_ff @(posedge clk) begin
		if (write_ena_1) begin
			mem[addr_1] <= wdata_1;
		end
	end

	always_ff @(posedge clk) begin
		if (read_ena_1) begin
			rdata_1 <= mem[addr_1];
		end
	end

	// port 2 feeds the write stage of the engine.
	always_ff @(posedge clk) begin
		if (read_ena_2) begin
			rdata_2 <= mem[addr_2];
		end
	end

	// the port arbitration upstream never reads and writes port 1 in one cycle.
	assert property (@(posedge clk) !(read_ena_1 && write_ena_1))
		else $error("ram_2port: port 1 read and write enabled together");

endmodule

/* xfer_counter.sv */
// ########################################
// address counter of the block mover.
// walks source and destination addresses
// over a region and flags its last word.
// ########################################

`timescale 1ns/1ns

module xfer_counter #(
	parameter int ADDR_BITS = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 load,
	input  logic                 step,
	input  logic [ADDR_BITS-1:0] src_base,
	input  logic [ADDR_BITS-1:0] dst_base,
	input  logic [ADDR_BITS-1:0] count,
	output logic [ADDR_BITS-1:0] rd_addr,
	output logic [ADDR_BITS-1:0] wr_addr,
	output logic                 last,
	output logic                 empty
);

	logic [ADDR_BITS-1:0] remaining;

	// addresses wrap at the top of memory by plain overflow.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_addr   <= '0;
			wr_addr   <= '0;
			remaining <= '0;
		end else if (load) begin
			rd_addr   <= src_base;
			wr_addr   <= dst_base;
			remaining <= count;
		end else if (step) begin
			rd_addr   <= rd_addr + 1'b1;
			wr_addr   <= wr_addr + 1'b1;
			remaining <= remaining - 1'b1;
		end
	end

	assign last  = (remaining == ADDR_BITS'(1));
	assign empty = (remaining == '0);

	// the FSM has to stop issuing once the region is used up.
	assert property (@(posedge clk) disable iff (!rst_n) step |-> !empty)
		else $error("xfer_counter: step with no words remaining");

endmodule

/* xfer_fsm.sv */
// ########################################
// command FSM of the block mover.
// accepts a start pulse, steps the counter
// one word per cycle and signals busy/done.
// ########################################

`timescale 1ns/1ns

module xfer_fsm (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  mem_cmd_pkg::mem_op_t op,
	input  logic                 empty,
	input  logic                 last,
	output logic                 load,
	output logic                 step,
	output mem_cmd_pkg::mem_op_t run_op,
	output logic                 clear_sum,
	output logic                 busy,
	output logic                 done
);

	mem_cmd_pkg::xfer_state_t state;
	mem_cmd_pkg::xfer_state_t state_nxt;

	logic accept;

	// a start pulse only counts while the engine is idle.
	assign accept = (state == mem_cmd_pkg::ST_IDLE) && start;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mem_cmd_pkg::ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// the opcode is held for the whole command.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_op <= mem_cmd_pkg::OP_FILL;
		end else if (accept) begin
			run_op <= op;
		end
	end

	// the counter is loaded on the start edge.
	// in ST_RUN its empty flag is valid, so a zero count skips to ST_DONE.
	always_comb begin
		state_nxt = state;
		case (state)
			mem_cmd_pkg::ST_IDLE: begin
				if (start) begin
					state_nxt = mem_cmd_pkg::ST_RUN;
				end
			end
			mem_cmd_pkg::ST_RUN: begin
				if (empty) begin
					state_nxt = mem_cmd_pkg::ST_DONE;
				end else if (last) begin
					state_nxt = mem_cmd_pkg::ST_DRAIN;
				end
			end
			mem_cmd_pkg::ST_DRAIN: begin
				state_nxt = mem_cmd_pkg::ST_DONE;
			end
			mem_cmd_pkg::ST_DONE: begin
				state_nxt = mem_cmd_pkg::ST_IDLE;
			end
			default: begin
				state_nxt = mem_cmd_pkg::ST_IDLE;
			end
		endcase
	end

	assign load      = accept;
	assign clear_sum = accept;
	assign step      = (state == mem_cmd_pkg::ST_RUN) && !empty;
	assign busy      = (state != mem_cmd_pkg::ST_IDLE);
	assign done      = (state == mem_cmd_pkg::ST_DONE);

	assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else $error("xfer_fsm: done longer than one cycle");

	assert property (@(posedge clk) disable iff (!rst_n)
		step |-> state == mem_cmd_pkg::ST_RUN)
		else $error("xfer_fsm: step outside ST_RUN");

endmodule

/* copy_datapath.sv */
// ########################################
// write stage of the block mover.
// arbitrates RAM port 1 between host and
// engine and accumulates the region sum.
// ########################################

`timescale 1ns/1ns

module copy_datapath #(
	parameter int ADDR_BITS = 8,
	parameter int WORD_BITS = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 step,
	input  mem_cmd_pkg::mem_op_t run_op,
	input  logic                 busy,
	input  logic                 clear_sum,
	input  logic [ADDR_BITS-1:0] wr_addr,
	input  logic [WORD_BITS-1:0] fill_value,
	input  logic [WORD_BITS-1:0] rdata_2,

	// host side of port 1.
	input  logic                 host_read_ena,
	input  logic                 host_write_ena,
	input  logic [ADDR_BITS-1:0] host_addr,
	input  logic [WORD_BITS-1:0] host_wdata,

	// RAM side of port 1.
	output logic                 ram_read_ena_1,
	output logic                 ram_write_ena_1,
	output logic [ADDR_BITS-1:0] ram_addr_1,
	output logic [WORD_BITS-1:0] ram_wdata_1,

	output logic [WORD_BITS-1:0] sum_result
);

	logic                 wr_valid;
	logic [ADDR_BITS-1:0] wr_addr_q;
	logic                 eng_write;
	logic                 eng_add;

	// the write stage sees the word one cycle after its issue,
	// when the port-2 read data is on rdata_2.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_valid <= 1'b0;
		end else begin
			wr_valid <= step;
		end
	end

	always_ff @(posedge clk) begin
		if (step) begin
			wr_addr_q <= wr_addr;
		end
	end

	assign eng_write = wr_valid && (run_op != mem_cmd_pkg::OP_SUM);
	assign eng_add   = wr_valid && (run_op == mem_cmd_pkg::OP_SUM);

	// while busy the host is shut out of port 1.
	// a host write wins over a host read in the same cycle.
	always_comb begin
		if (busy) begin
			ram_read_ena_1  = 1'b0;
			ram_write_ena_1 = eng_write;
			ram_addr_1      = wr_addr_q;
			ram_wdata_1     = (run_op == mem_cmd_pkg::OP_FILL) ? fill_value : rdata_2;
		end else begin
			ram_read_ena_1  = host_read_ena && !host_write_ena;
			ram_write_ena_1 = host_write_ena;
			ram_addr_1      = host_addr;
			ram_wdata_1     = host_wdata;
		end
	end

	// the sum wraps at the word width and holds until the next command.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum_result <= '0;
		end else if (clear_sum) begin
			sum_result <= '0;
		end else if (eng_add) begin
			sum_result <= sum_result + rdata_2;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(step && run_op == mem_cmd_pkg::OP_SUM) |=> !ram_write_ena_1)
		else $error("copy_datapath: engine write during a sum");

endmodule

/* block_mover.sv */
// ########################################
// block-transfer engine around a two-port
// RAM. the host owns port 1 while idle, a
// start pulse runs fill, copy or sum.
// ########################################

`timescale 1ns/1ns

module block_mover #(
	parameter int ADDR_BITS = mem_cfg_pkg::ADDR_BITS_DEF,
	parameter int WORD_BITS = mem_cfg_pkg::WORD_BITS_DEF
) (
	input  logic                 clk,
	input  logic                 rst_n,

	// host port.
	input  logic                 host_read_ena,
	input  logic                 host_write_ena,
	input  logic [ADDR_BITS-1:0] host_addr,
	input  logic [WORD_BITS-1:0] host_wdata,
	output logic [WORD_BITS-1:0] host_rdata,

	// command port.
	input  logic                 start,
	input  mem_cmd_pkg::mem_op_t op,
	input  logic [ADDR_BITS-1:0] src_addr,
	input  logic [ADDR_BITS-1:0] dst_addr,
	input  logic [ADDR_BITS-1:0] count,
	input  logic [WORD_BITS-1:0] fill_value,
	output logic                 busy,
	output logic                 done,
	output logic [WORD_BITS-1:0] sum_result
);

	logic                 load;
	logic                 step;
	logic                 last;
	logic                 empty;
	logic                 clear_sum;
	mem_cmd_pkg::mem_op_t run_op;
	logic [ADDR_BITS-1:0] rd_addr;
	logic [ADDR_BITS-1:0] wr_addr;
	logic                 ram_read_ena_1;
	logic                 ram_write_ena_1;
	logic [ADDR_BITS-1:0] ram_addr_1;
	logic [WORD_BITS-1:0] ram_wdata_1;
	logic [WORD_BITS-1:0] rdata_2;

	// port 2 reads the source word in the issue cycle.
	ram_2port #(.ADDR_BITS(ADDR_BITS), .WORD_BITS(WORD_BITS)) ram (
		.clk(clk),
		.read_ena_1(ram_read_ena_1), .write_ena_1(ram_write_ena_1),
		.addr_1(ram_addr_1), .wdata_1(ram_wdata_1), .rdata_1(host_rdata),
		.read_ena_2(step), .addr_2(rd_addr), .rdata_2(rdata_2)
	);

	xfer_counter #(.ADDR_BITS(ADDR_BITS)) counter (
		.clk(clk), .rst_n(rst_n), .load(load), .step(step),
		.src_base(src_addr), .dst_base(dst_addr), .count(count),
		.rd_addr(rd_addr), .wr_addr(wr_addr), .last(last), .empty(empty)
	);

	xfer_fsm fsm (
		.clk(clk), .rst_n(rst_n), .start(start), .op(op),
		.empty(empty), .last(last), .load(load), .step(step),
		.run_op(run_op), .clear_sum(clear_sum), .busy(busy), .done(done)
	);

	copy_datapath #(.ADDR_BITS(ADDR_BITS), .WORD_BITS(WORD_BITS)) datapath (
		.clk(clk), .rst_n(rst_n), .step(step), .run_op(run_op),
		.busy(busy), .clear_sum(clear_sum), .wr_addr(wr_addr),
		.fill_value(fill_value), .rdata_2(rdata_2),
		.host_read_ena(host_read_ena), .host_write_ena(host_write_ena),
		.host_addr(host_addr), .host_wdata(host_wdata),
		.ram_read_ena_1(ram_read_ena_1), .ram_write_ena_1(ram_write_ena_1),
		.ram_addr_1(ram_addr_1), .ram_wdata_1(ram_wdata_1),
		.sum_result(sum_result)
	);

endmodule

/* block_mover_tb.sv */
// ########################################
// directed testbench of the block mover.
// keeps a reference copy of the memory and
// runs host, fill, copy, sum and control tests.
// ########################################

`timescale 1ns/1ns

module block_mover_tb;

	localparam int ADDR_BITS  = mem_cfg_pkg::ADDR_BITS_DEF;
	localparam int WORD_BITS  = mem_cfg_pkg::WORD_BITS_DEF;
	localparam int NUM_WORDS  = 1 << ADDR_BITS;
	localparam int CLK_PERIOD = 100;
	localparam int HOST_WORDS = 16;
	localparam int FILL_COUNT = 24;
	localparam int COPY_COUNT = 40;
	localparam int SUM_COUNT  = 50;
	localparam int CTRL_COUNT = 30;
	localparam int MARGIN     = 200;

	// five full memory passes plus the host test and every command region.
	localparam int WATCHDOG_CYCLES = 5 * NUM_WORDS + 2 * HOST_WORDS + FILL_COUNT
		+ COPY_COUNT + SUM_COUNT + CTRL_COUNT + MARGIN;

	logic                 clk;
	logic                 rst_n;
	logic                 host_read_ena;
	logic                 host_write_ena;
	logic [ADDR_BITS-1:0] host_addr;
	logic [WORD_BITS-1:0] host_wdata;
	logic [WORD_BITS-1:0] host_rdata;
	logic                 start;
	mem_cmd_pkg::mem_op_t op;
	logic [ADDR_BITS-1:0] src_addr;
	logic [ADDR_BITS-1:0] dst_addr;
	logic [ADDR_BITS-1:0] count;
	logic [WORD_BITS-1:0] fill_value;
	logic                 busy;
	logic                 done;
	logic [WORD_BITS-1:0] sum_result;

	logic [WORD_BITS-1:0] model [0:NUM_WORDS-1];
	logic [15:0]          lfsr_state;
	int                   errors;

	block_mover #(.ADDR_BITS(ADDR_BITS), .WORD_BITS(WORD_BITS)) uut (
		.clk(clk), .rst_n(rst_n),
		.host_read_ena(host_read_ena), .host_write_ena(host_write_ena),
		.host_addr(host_addr), .host_wdata(host_wdata), .host_rdata(host_rdata),
		.start(start), .op(op), .src_addr(src_addr), .dst_addr(dst_addr),
		.count(count), .fill_value(fill_value),
		.busy(busy), .done(done), .sum_result(sum_result)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the run went past %0d clock cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11, one step per bit.
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	task automatic check_word(input string name, input logic [WORD_BITS-1:0] got,
		input logic [WORD_BITS-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// all tasks below start and end just after a falling edge.
	task automatic host_write(input logic [ADDR_BITS-1:0] a, input logic [WORD_BITS-1:0] d);
		host_write_ena = 1'b1;
		host_addr = a;
		host_wdata = d;
		@(negedge clk);
		host_write_ena = 1'b0;
		model[a] = d;
	endtask

	task automatic host_read_check(input logic [ADDR_BITS-1:0] a);
		host_read_ena = 1'b1;
		host_addr = a;
		@(negedge clk);
		host_read_ena = 1'b0;
		check_word($sformatf("host_rdata[%h]", a), host_rdata, model[a]);
	endtask

	task automatic verify_memory();
		for (int i = 0; i < NUM_WORDS; i++) begin
			host_read_check(ADDR_BITS'(i));
		end
	endtask

	// the multiplier is odd, so every address gets its own word.
	task automatic init_memory();
		for (int i = 0; i < NUM_WORDS; i++) begin
			host_write(ADDR_BITS'(i), WORD_BITS'(i * 37 + 11));
		end
	endtask

	// with disturb set, a second start and a host write hit the first busy cycle.
	task automatic run_command(input mem_cmd_pkg::mem_op_t cmd_op,
		input logic [ADDR_BITS-1:0] src, input logic [ADDR_BITS-1:0] dst,
		input logic [ADDR_BITS-1:0] cnt, input logic [WORD_BITS-1:0] fill,
		input logic [WORD_BITS-1:0] exp_sum, input bit disturb,
		input logic [ADDR_BITS-1:0] probe_addr);
		int cycles;
		int timeout;
		cycles = 0;
		timeout = int'(cnt) + 8;
		check_flag("busy", busy, 1'b0);
		op = cmd_op;
		src_addr = src;
		dst_addr = dst;
		count = cnt;
		fill_value = fill;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (disturb) begin
			start = 1'b1;
			op = mem_cmd_pkg::OP_FILL;
			dst_addr = probe_addr;
			host_write_ena = 1'b1;
			host_addr = probe_addr;
			host_wdata = ~model[probe_addr];
		end
		while (!done && cycles < timeout) begin
			check_flag("busy", busy, 1'b1);
			@(negedge clk);
			cycles++;
			start = 1'b0;
			host_write_ena = 1'b0;
			op = cmd_op;
		end
		if (!done) begin
			errors++;
			$display("no done pulse within %0d cycles of the start pulse", timeout);
		end else begin
			check_flag("busy", busy, 1'b1);
			if (cmd_op == mem_cmd_pkg::OP_SUM) begin
				check_word("sum_result", sum_result, exp_sum);
			end
		end
		@(negedge clk);
		check_flag("done", done, 1'b0);
		check_flag("busy", busy, 1'b0);
		if (cmd_op == mem_cmd_pkg::OP_SUM) begin
			check_word("sum_result", sum_result, exp_sum);
		end
	endtask

	// random addresses stay in the lower half, so the upper half has unwritten words.
	task automatic exercise_host_port();
		logic [ADDR_BITS-1:0] addrs [HOST_WORDS];
		logic [ADDR_BITS-1:0] untouched;
		for (int i = 0; i < HOST_WORDS; i++) begin
			addrs[i] = ADDR_BITS'(random_bits(ADDR_BITS - 1));
			host_write(addrs[i], WORD_BITS'(random_bits(WORD_BITS)));
		end
		for (int i = 0; i < HOST_WORDS; i++) begin
			host_read_check(addrs[i]);
		end
		untouched = ADDR_BITS'(random_bits(ADDR_BITS - 1)) | ADDR_BITS'(NUM_WORDS / 2);
		host_write(addrs[0], WORD_BITS'(random_bits(WORD_BITS)));
		host_read_check(untouched);
	endtask

	task automatic fill_wrapped_region();
		logic [ADDR_BITS-1:0] base;
		logic [WORD_BITS-1:0] value;
		base = ADDR_BITS'(NUM_WORDS - FILL_COUNT / 2);
		value = WORD_BITS'(random_bits(WORD_BITS));
		run_command(mem_cmd_pkg::OP_FILL, '0, base, ADDR_BITS'(FILL_COUNT), value, '0, 1'b0, '0);
		for (int i = 0; i < FILL_COUNT; i++) begin
			model[base + ADDR_BITS'(i)] = value;
		end
		verify_memory();
	endtask

	task automatic copy_region();
		logic [ADDR_BITS-1:0] src;
		logic [ADDR_BITS-1:0] dst;
		src = ADDR_BITS'(random_bits(ADDR_BITS));
		dst = src + ADDR_BITS'(NUM_WORDS / 2);
		run_command(mem_cmd_pkg::OP_COPY, src, dst, ADDR_BITS'(COPY_COUNT), '0, '0, 1'b0, '0);
		for (int i = 0; i < COPY_COUNT; i++) begin
			model[dst + ADDR_BITS'(i)] = model[src + ADDR_BITS'(i)];
		end
		verify_memory();
	endtask

	task automatic sum_region();
		logic [ADDR_BITS-1:0] src;
		logic [WORD_BITS-1:0] expected;
		src = ADDR_BITS'(random_bits(ADDR_BITS));
		expected = '0;
		for (int i = 0; i < SUM_COUNT; i++) begin
			expected += model[src + ADDR_BITS'(i)];
		end
		run_command(mem_cmd_pkg::OP_SUM, src, '0, ADDR_BITS'(SUM_COUNT), '0, expected, 1'b0, '0);
		run_command(mem_cmd_pkg::OP_SUM, src, '0, '0, '0, '0, 1'b0, '0);
		verify_memory();
	endtask

	// the ignored start would fill the probe region, so memory shows if it ran.
	task automatic ignore_start_while_busy();
		logic [ADDR_BITS-1:0] src;
		logic [ADDR_BITS-1:0] probe;
		logic [WORD_BITS-1:0] expected;
		src = ADDR_BITS'(random_bits(ADDR_BITS));
		probe = src + ADDR_BITS'(NUM_WORDS / 2);
		expected = '0;
		for (int i = 0; i < CTRL_COUNT; i++) begin
			expected += model[src + ADDR_BITS'(i)];
		end
		run_command(mem_cmd_pkg::OP_SUM, src, '0, ADDR_BITS'(CTRL_COUNT),
			WORD_BITS'(random_bits(WORD_BITS)), expected, 1'b1, probe);
		repeat (2) begin
			@(negedge clk);
			check_flag("busy", busy, 1'b0);
		end
		verify_memory();
	endtask

	initial begin
		errors = 0;
		lfsr_state = 16'd31;
		rst_n = 1'b0;
		host_read_ena = 1'b0;
		host_write_ena = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		start = 1'b0;
		op = mem_cmd_pkg::OP_FILL;
		src_addr = '0;
		dst_addr = '0;
		count = '0;
		fill_value = '0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_word("sum_result", sum_result, '0);
		init_memory();
		exercise_host_port();
		fill_wrapped_region();
		copy_region();
		sum_region();
		ignore_start_while_busy();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* vlog.f */
mem_cfg_pkg.sv
mem_cmd_pkg.sv
ram_2port.sv
xfer_counter.sv
xfer_fsm.sv
copy_datapath.sv
block_mover.sv
block_mover_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the block mover testbench with Verilator, run it and check the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module block_mover_tb -f vlog.f \
	-o block_mover_sim || { echo "build failed"; exit 1; }
./obj_dir/block_mover_sim > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }
